// File: rtl/ilv_defs.svh
`ifndef ILV_DEFS_SVH
`define ILV_DEFS_SVH

// Set to 1 for the full-size FPGA build, 0 for the small simulation geometry
`define ILV_ON_FPGA 0

// Block geometry, rows are walked fastest and columns slowest
`define ILV_ROWS ((`ILV_ON_FPGA != 0) ? 72 : 6)
`define ILV_COLS ((`ILV_ON_FPGA != 0) ? 176 : 8)

// Address step from one row to the next
`define ILV_STRIDE ((`ILV_ON_FPGA != 0) ? 240 : 10)

// Cycles from a read strobe to its data valid
`define ILV_READ_LAT 4

// Frame period is TMR_PRESCALE * TMR_COUNT clock cycles
`define TMR_PRESCALE 16
`define TMR_COUNT ((`ILV_ON_FPGA != 0) ? 2500000 : 32)

// CRC-8, x^8 + x^2 + x + 1
`define CRC_POLY 8'h07

`endif

// File: rtl/ilv_pkg.sv
package ilv_pkg;

   // Row index inside a block
   typedef logic [8:0] row_t;

   // Column index inside a block
   typedef logic [7:0] col_t;

   // Memory address, row times stride plus column
   typedef logic [16:0] addr_t;

   typedef logic [7:0] byte_t;

   // Reads issued or bytes received within one block
   typedef logic [13:0] rd_count_t;

endpackage

// File: rtl/ctrl_pkg.sv
package ctrl_pkg;

   // Block reader FSM
   typedef enum logic [1:0]
   {
      IDLE  = 2'd0,
      READ  = 2'd1,
      DRAIN = 2'd2
   } reader_state_e;

   typedef logic [7:0] crc_t;

endpackage

// File: rtl/frame_timer.sv
`timescale 1ns/1ns
`include "ilv_defs.svh"

module frame_timer
(
   input  logic clk,
   input  logic reset_n,
   output logic frame_irq
);

   localparam int SLOW_W = $clog2(`TMR_COUNT);

   logic [3:0]        prescale;
   logic              tick;
   logic [SLOW_W-1:0] slow_cnt;
   logic              wrap;

   // One-cycle enable every TMR_PRESCALE clocks
   assign tick = (prescale == 4'(`TMR_PRESCALE - 1));
   assign wrap = tick && (slow_cnt == SLOW_W'(`TMR_COUNT - 1));

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         prescale <= '0;
      end
      else if (tick)
      begin
         prescale <= '0;
      end
      else
      begin
         prescale <= prescale + 4'd1;
      end
   end

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         slow_cnt  <= '0;
         frame_irq <= 1'b0;
      end
      else
      begin
         frame_irq <= wrap;
         if (wrap)
         begin
            slow_cnt <= '0;
         end
         else if (tick)
         begin
            slow_cnt <= slow_cnt + 1'b1;
         end
      end
   end

   a_irq_single: assert property (@(posedge clk) disable iff (!reset_n)
      frame_irq |=> !frame_irq);

endmodule

// File: rtl/read_ctrl.sv
`timescale 1ns/1ns
`include "ilv_defs.svh"

module read_ctrl
(
   input  logic clk,
   input  logic reset_n,
   input  logic frame_irq,
   input  logic enable,
   input  logic hold,
   input  logic block_done,
   output logic mem_rd_ena,
   output logic overrun
);

   localparam int BLOCK_LEN = `ILV_ROWS * `ILV_COLS;

   ctrl_pkg::reader_state_e state;
   ilv_pkg::rd_count_t      issued;
   logic                    last_strobe;

   // Hold takes effect at once so no strobe slips out after it rises
   assign mem_rd_ena  = (state == ctrl_pkg::READ) && !hold;
   assign last_strobe = mem_rd_ena && (issued == ilv_pkg::rd_count_t'(BLOCK_LEN - 1));

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         state  <= ctrl_pkg::IDLE;
         issued <= '0;
      end
      else
      begin
         case (state)
            ctrl_pkg::IDLE:
            begin
               if (frame_irq && enable)
               begin
                  state <= ctrl_pkg::READ;
               end
            end
            ctrl_pkg::READ:
            begin
               if (last_strobe)
               begin
                  state  <= ctrl_pkg::DRAIN;
                  issued <= '0;
               end
               else if (mem_rd_ena)
               begin
                  issued <= issued + 1'b1;
               end
            end
            ctrl_pkg::DRAIN:
            begin
               // Wait for the CRC block to see the last byte come back
               if (block_done)
               begin
                  state <= ctrl_pkg::IDLE;
               end
            end
            default:
            begin
               state <= ctrl_pkg::IDLE;
            end
         endcase
      end
   end

   // A frame that finds the reader busy is dropped and reported
   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         overrun <= 1'b0;
      end
      else
      begin
         overrun <= frame_irq && (state != ctrl_pkg::IDLE);
      end
   end

   a_ena_in_read: assert property (@(posedge clk) disable iff (!reset_n)
      mem_rd_ena |-> (state == ctrl_pkg::READ));

   a_ena_no_hold: assert property (@(posedge clk) disable iff (!reset_n)
      hold |-> !mem_rd_ena);

endmodule

// File: rtl/mem_source.sv
`timescale 1ns/1ns
`include "ilv_defs.svh"

module mem_source
(
   input  logic           clk,
   input  logic           reset_n,
   input  logic           mem_rd_ena,
   output ilv_pkg::byte_t mem_data,
   output logic           mem_data_valid
);

   ilv_pkg::row_t            row;
   ilv_pkg::col_t            col;
   ilv_pkg::addr_t           addr;
   ilv_pkg::byte_t           rd_byte;
   logic [`ILV_READ_LAT-1:0] rd_pipe;
   logic                     row_last;
   logic                     col_last;

   assign row_last = (row == ilv_pkg::row_t'(`ILV_ROWS - 1));
   assign col_last = (col == ilv_pkg::col_t'(`ILV_COLS - 1));

   // Strobe delay line, bit n marks a read in stage n
   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         rd_pipe <= '0;
      end
      else
      begin
         rd_pipe <= {rd_pipe[`ILV_READ_LAT-2:0], mem_rd_ena};
      end
   end

   // Rows run fastest, the column steps once per full pass of rows
   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         row <= '0;
         col <= '0;
      end
      else if (rd_pipe[0])
      begin
         if (row_last)
         begin
            row <= '0;
            if (col_last)
            begin
               col <= '0;
            end
            else
            begin
               col <= col + 1'b1;
            end
         end
         else
         begin
            row <= row + 1'b1;
         end
      end
   end

   // Address, lookup and output stages of the read pipeline
   always_ff @(posedge clk)
   begin
      if (rd_pipe[0])
      begin
         addr <= ilv_pkg::addr_t'(row) * ilv_pkg::addr_t'(`ILV_STRIDE)
               + ilv_pkg::addr_t'(col);
      end
      if (rd_pipe[1])
      begin
         rd_byte <= addr[16:9] ^ addr[7:0];
      end
      if (rd_pipe[2])
      begin
         mem_data <= rd_byte;
      end
   end

   assign mem_data_valid = rd_pipe[`ILV_READ_LAT-1];

   a_row_range: assert property (@(posedge clk) disable iff (!reset_n)
      row < ilv_pkg::row_t'(`ILV_ROWS));

endmodule

// File: rtl/block_crc.sv
`timescale 1ns/1ns
`include "ilv_defs.svh"

module block_crc
(
   input  logic           clk,
   input  logic           reset_n,
   input  logic           mem_data_valid,
   input  ilv_pkg::byte_t mem_data,
   output logic           block_done,
   output ctrl_pkg::crc_t block_crc_value
);

   localparam int BLOCK_LEN = `ILV_ROWS * `ILV_COLS;

   ctrl_pkg::crc_t     crc;
   ctrl_pkg::crc_t     crc_next;
   ilv_pkg::rd_count_t byte_cnt;
   logic               last_byte;

   // MSB-first CRC-8 over one byte
   function automatic ctrl_pkg::crc_t crc8_fold(ctrl_pkg::crc_t crc_in, ilv_pkg::byte_t data);
      ctrl_pkg::crc_t c;
      c = crc_in ^ data;
      for (int i = 0; i < 8; i++)
      begin
         if (c[7])
         begin
            c = (c << 1) ^ `CRC_POLY;
         end
         else
         begin
            c = c << 1;
         end
      end
      return c;
   endfunction

   assign crc_next  = crc8_fold(crc, mem_data);
   assign last_byte = mem_data_valid && (byte_cnt == ilv_pkg::rd_count_t'(BLOCK_LEN - 1));

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         crc        <= '0;
         byte_cnt   <= '0;
         block_done <= 1'b0;
      end
      else
      begin
         block_done <= last_byte;
         if (last_byte)
         begin
            crc      <= '0;
            byte_cnt <= '0;
         end
         else if (mem_data_valid)
         begin
            crc      <= crc_next;
            byte_cnt <= byte_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (last_byte)
      begin
         block_crc_value <= crc_next;
      end
   end

endmodule

// File: rtl/block_reader_top.sv
`timescale 1ns/1ns

module block_reader_top
(
   input  logic           clk,
   input  logic           reset_n,
   input  logic           enable,
   input  logic           hold,
   output ilv_pkg::byte_t mem_data,
   output logic           mem_data_valid,
   output logic           frame_irq,
   output logic           block_done,
   output logic           overrun,
   output ctrl_pkg::crc_t block_crc_value
);

   logic mem_rd_ena;

   frame_timer u_frame_timer
   (
      .clk       (clk),
      .reset_n   (reset_n),
      .frame_irq (frame_irq)
   );

   read_ctrl u_read_ctrl
   (
      .clk        (clk),
      .reset_n    (reset_n),
      .frame_irq  (frame_irq),
      .enable     (enable),
      .hold       (hold),
      .block_done (block_done),
      .mem_rd_ena (mem_rd_ena),
      .overrun    (overrun)
   );

   mem_source u_mem_source
   (
      .clk            (clk),
      .reset_n        (reset_n),
      .mem_rd_ena     (mem_rd_ena),
      .mem_data       (mem_data),
      .mem_data_valid (mem_data_valid)
   );

   block_crc u_block_crc
   (
      .clk             (clk),
      .reset_n         (reset_n),
      .mem_data_valid  (mem_data_valid),
      .mem_data        (mem_data),
      .block_done      (block_done),
      .block_crc_value (block_crc_value)
   );

endmodule

// File: bench/block_checker.sv
`timescale 1ns/1ns
`include "ilv_defs.svh"

module block_checker
(
   input  logic           clk,
   input  logic           reset_n,
   input  logic           enable,
   input  ilv_pkg::byte_t mem_data,
   input  logic           mem_data_valid,
   input  logic           frame_irq,
   input  logic           block_done,
   input  logic           overrun,
   input  ctrl_pkg::crc_t block_crc_value,
   input  logic           test_active,
   input  logic [191:0]   test_name,
   input  int             test_mode,
   input  int             exp_blocks,
   input  ctrl_pkg::crc_t exp_crc,
   output int             tests_run,
   output int             tests_failed,
   output int             error_count
);

   localparam int BLOCK_LEN    = `ILV_ROWS * `ILV_COLS;
   localparam int FRAME_CYCLES = `TMR_PRESCALE * `TMR_COUNT;
   localparam int IRQ_TO_DATA  = 5;

   int             cycle;
   int             last_irq;
   int             since_irq;
   logic           lat_armed;
   int             pred_row;
   int             pred_col;
   ctrl_pkg::crc_t crc;
   int             blk_bytes;
   int             blocks_seen;
   int             overruns_seen;
   int             test_errs;
   logic           was_active;
   logic           enable_dropped;

   // Byte stored at the interleaved address row * stride + col
   function automatic ilv_pkg::byte_t expected_byte(int row, int col);
      logic [16:0] a;
      a = row * `ILV_STRIDE + col;
      return a[16:9] ^ a[7:0];
   endfunction

   // Bit-serial CRC-8, data MSB first
   function automatic ctrl_pkg::crc_t crc_step(ctrl_pkg::crc_t crc_in, ilv_pkg::byte_t d);
      ctrl_pkg::crc_t c;
      logic           fb;
      c = crc_in;
      for (int i = 7; i >= 0; i--)
      begin
         fb = c[7] ^ d[i];
         c  = {c[6:0], 1'b0};
         if (fb)
         begin
            c = c ^ `CRC_POLY;
         end
      end
      return c;
   endfunction

   task automatic count_error();
      error_count++;
      test_errs++;
   endtask

   task automatic check_block();
      if (blk_bytes != BLOCK_LEN)
      begin
         $display("ERROR %0s: bytes per block expected %0d actual %0d", test_name, BLOCK_LEN,
                  blk_bytes);
         count_error();
      end
      if (block_crc_value !== crc)
      begin
         $display("ERROR %0s: block CRC expected %h actual %h", test_name, crc, block_crc_value);
         count_error();
      end
      if (block_crc_value !== exp_crc)
      begin
         $display("ERROR %0s: CRC from case file expected %h actual %h", test_name, exp_crc,
                  block_crc_value);
         count_error();
      end
      blocks_seen++;
      crc       = '0;
      blk_bytes = 0;
      if (test_mode == 3)
      begin
         enable_dropped = 1'b1;
      end
   endtask

   task automatic check_byte();
      ilv_pkg::byte_t exp;
      exp = expected_byte(pred_row, pred_col);
      if (mem_data !== exp)
      begin
         $display("ERROR %0s: byte at row %0d col %0d expected %h actual %h", test_name,
                  pred_row, pred_col, exp, mem_data);
         count_error();
      end
      if (enable_dropped)
      begin
         $display("Test %0s: a data byte arrived after enable was dropped and the block ended",
                  test_name);
         count_error();
      end
      crc = crc_step(crc, exp);
      blk_bytes++;
      pred_row++;
      if (pred_row == `ILV_ROWS)
      begin
         pred_row = 0;
         pred_col = (pred_col + 1) % `ILV_COLS;
      end
   endtask

   task automatic track_latency();
      if (lat_armed)
      begin
         since_irq++;
         if (mem_data_valid || since_irq > IRQ_TO_DATA)
         begin
            lat_armed = 1'b0;
            if (since_irq != IRQ_TO_DATA)
            begin
               $display("ERROR %0s: cycles from frame_irq to first byte expected %0d actual %0d",
                        test_name, IRQ_TO_DATA, since_irq);
               count_error();
            end
         end
      end
      if (frame_irq && enable && test_active && (test_mode == 0 || test_mode == 3))
      begin
         lat_armed = 1'b1;
         since_irq = 0;
      end
   endtask

   task automatic finish_test();
      if (blocks_seen != exp_blocks)
      begin
         $display("ERROR %0s: blocks expected %0d actual %0d", test_name, exp_blocks,
                  blocks_seen);
         count_error();
      end
      if (test_mode == 2 && overruns_seen == 0)
      begin
         $display("Test %0s: hold stayed high past a frame interrupt but no overrun came",
                  test_name);
         count_error();
      end
      tests_run++;
      if (test_errs == 0)
      begin
         $display("PASS %0s  blocks %0d  overruns %0d", test_name, blocks_seen, overruns_seen);
      end
      else
      begin
         tests_failed++;
         $display("FAIL %0s  %0d errors", test_name, test_errs);
      end
   endtask

   initial
   begin
      tests_run      = 0;
      tests_failed   = 0;
      error_count    = 0;
      cycle          = 0;
      last_irq       = -1;
      lat_armed      = 1'b0;
      pred_row       = 0;
      pred_col       = 0;
      crc            = '0;
      blk_bytes      = 0;
      test_errs      = 0;
      was_active     = 1'b0;
      enable_dropped = 1'b0;
   end

   always @(posedge clk)
   begin
      if (reset_n)
      begin
         cycle++;
         if (test_active && !was_active)
         begin
            test_errs      = 0;
            blocks_seen    = 0;
            overruns_seen  = 0;
            enable_dropped = 1'b0;
            lat_armed      = 1'b0;
         end
         if (frame_irq)
         begin
            if (last_irq >= 0 && cycle - last_irq != FRAME_CYCLES)
            begin
               $display("ERROR %0s: frame_irq period expected %0d actual %0d", test_name,
                        FRAME_CYCLES, cycle - last_irq);
               count_error();
            end
            last_irq = cycle;
         end
         track_latency();
         // A block_done closes the bytes before it, so it goes first
         if (block_done)
         begin
            check_block();
         end
         if (mem_data_valid)
         begin
            check_byte();
         end
         if (overrun)
         begin
            overruns_seen++;
            if (test_mode != 2)
            begin
               $display("Test %0s: overrun pulsed although no frame was missed", test_name);
               count_error();
            end
         end
         if (!test_active && was_active)
         begin
            finish_test();
         end
         was_active = test_active;
      end
   end

endmodule

// File: bench/tb_block_reader.sv
`timescale 1ns/1ns
`include "ilv_defs.svh"

module tb_block_reader;

   localparam int FRAME_CYCLES = `TMR_PRESCALE * `TMR_COUNT;
   localparam int MAX_CASES    = 16;

   logic           clk = 1'b0;
   logic           reset_n;
   logic           enable;
   logic           hold;
   ilv_pkg::byte_t mem_data;
   logic           mem_data_valid;
   logic           frame_irq;
   logic           block_done;
   logic           overrun;
   ctrl_pkg::crc_t block_crc_value;

   logic [191:0]   test_name;
   int             test_mode;
   int             exp_blocks;
   ctrl_pkg::crc_t exp_crc;
   logic           test_active;
   int             tests_run;
   int             tests_failed;
   int             error_count;

   logic [191:0]   case_name [MAX_CASES];
   int             case_mode [MAX_CASES];
   int             case_blocks [MAX_CASES];
   ctrl_pkg::crc_t case_crc [MAX_CASES];
   int             num_cases;
   int unsigned    cycle_count = 0;
   int unsigned    cycle_limit = 0;
   int unsigned    rng_seed;

   always #10 clk = ~clk;

   block_reader_top dut
   (
      .clk             (clk),
      .reset_n         (reset_n),
      .enable          (enable),
      .hold            (hold),
      .mem_data        (mem_data),
      .mem_data_valid  (mem_data_valid),
      .frame_irq       (frame_irq),
      .block_done      (block_done),
      .overrun         (overrun),
      .block_crc_value (block_crc_value)
   );

   block_checker u_checker
   (
      .clk             (clk),
      .reset_n         (reset_n),
      .enable          (enable),
      .mem_data        (mem_data),
      .mem_data_valid  (mem_data_valid),
      .frame_irq       (frame_irq),
      .block_done      (block_done),
      .overrun         (overrun),
      .block_crc_value (block_crc_value),
      .test_active     (test_active),
      .test_name       (test_name),
      .test_mode       (test_mode),
      .exp_blocks      (exp_blocks),
      .exp_crc         (exp_crc),
      .tests_run       (tests_run),
      .tests_failed    (tests_failed),
      .error_count     (error_count)
   );

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_limit != 0 && cycle_count >= cycle_limit)
      begin
         $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   task automatic load_cases();
      int             fd;
      int             n;
      logic [767:0]   line;
      logic [191:0]   name;
      int             mode;
      int             blocks;
      ctrl_pkg::crc_t crc;
      num_cases = 0;
      fd = $fopen("bench/reader_cases.txt", "r");
      if (fd != 0)
      begin
         while (!$feof(fd) && num_cases < MAX_CASES)
         begin
            line = '0;
            n = $fgets(line, fd);
            n = $sscanf(line, "%s %d %d %h", name, mode, blocks, crc);
            // Comment and blank lines do not yield all four fields
            if (n == 4)
            begin
               case_name[num_cases]   = name;
               case_mode[num_cases]   = mode;
               case_blocks[num_cases] = blocks;
               case_crc[num_cases]    = crc;
               num_cases++;
            end
         end
         $fclose(fd);
      end
   endtask

   // Each test may take its blocks plus two frames, with a factor of two to spare
   function automatic int unsigned timeout_limit();
      int unsigned total;
      total = 0;
      for (int i = 0; i < num_cases; i++)
      begin
         total += (case_blocks[i] + 2) * FRAME_CYCLES * 2;
      end
      return total;
   endfunction

   // Entered and left on a falling edge
   task automatic run_blocks(input int mode, input int count);
      int seen;
      seen = 0;
      while (seen < count)
      begin
         @(posedge clk);
         if (block_done)
         begin
            seen++;
         end
         @(negedge clk);
         if (mode == 1 && seen < count)
         begin
            hold = ($urandom % 2) != 0;
         end
      end
      hold = 1'b0;
   endtask

   task automatic run_case(input int idx);
      test_name   = case_name[idx];
      test_mode   = case_mode[idx];
      exp_blocks  = case_blocks[idx];
      exp_crc     = case_crc[idx];
      enable      = 1'b1;
      hold        = 1'b0;
      test_active = 1'b1;
      case (test_mode)
         2:
         begin
            // Long enough for two interrupts, so one of them finds the reader busy
            hold = 1'b1;
            repeat (2 * FRAME_CYCLES + 8) @(negedge clk);
            hold = 1'b0;
            run_blocks(0, exp_blocks);
         end
         3:
         begin
            run_blocks(0, exp_blocks);
            enable = 1'b0;
            repeat (2 * FRAME_CYCLES) @(negedge clk);
         end
         default:
         begin
            run_blocks(test_mode, exp_blocks);
         end
      endcase
      test_active = 1'b0;
      repeat (2) @(negedge clk);
   endtask

   task automatic report_summary();
      $display("Summary: %0d of %0d tests run, %0d failed, %0d errors", tests_run, num_cases,
               tests_failed, error_count);
      if (error_count == 0 && tests_failed == 0 && tests_run == num_cases)
      begin
         $display("ALL CHECKS PASSED");
      end
      else
      begin
         $display("CHECKS FAILED");
      end
   endtask

   initial
   begin
      reset_n     = 1'b0;
      enable      = 1'b0;
      hold        = 1'b0;
      test_active = 1'b0;
      test_name   = '0;
      test_mode   = 0;
      exp_blocks  = 0;
      exp_crc     = '0;
      rng_seed    = 32'h6098b2c0;
      void'($urandom(rng_seed));
      load_cases();
      if (num_cases == 0)
      begin
         $display("No test cases could be read from bench/reader_cases.txt");
         $display("CHECKS FAILED");
      end
      else
      begin
         cycle_limit = timeout_limit();
         repeat (10) @(posedge clk);
         @(negedge clk);
         reset_n = 1'b1;
         repeat (2) @(negedge clk);
         for (int i = 0; i < num_cases; i++)
         begin
            run_case(i);
         end
         report_summary();
      end
      $finish;
   end

endmodule

// File: bench/reader_cases.txt
# name  hold_mode  blocks  expected_crc_hex
# hold_mode 0 low, 1 random, 2 held past a frame, 3 enable drop after first block
straight_one 0 1 90
straight_three 0 3 90
random_hold 1 2 90
random_hold_long 1 4 90
hold_stall 2 1 90
straight_after_stall 0 1 90
random_after_stall 1 1 90
hold_stall_twice 2 2 90
enable_drop 3 1 90

// File: files.f
+incdir+rtl
rtl/ilv_pkg.sv
rtl/ctrl_pkg.sv
rtl/frame_timer.sv
rtl/read_ctrl.sv
rtl/mem_source.sv
rtl/block_crc.sv
rtl/block_reader_top.sv
bench/block_checker.sv
bench/tb_block_reader.sv
